/* aes_dec_pkg.sv */
package aes_dec_pkg;

    typedef logic [7:0]   byte_t;
    typedef logic [31:0]  word_t;
    typedef logic [127:0] block_t;
    typedef logic [3:0]   round_idx_t;
    typedef logic [7:0]   apb_addr_t;

    localparam round_idx_t NUM_ROUNDS = 4'd10;

    // index 0 is the constant for the first derived key
    localparam byte_t RCON [0:9] = '{
        8'h01, 8'h02, 8'h04, 8'h08, 8'h10,
        8'h20, 8'h40, 8'h80, 8'h1b, 8'h36
    };

    // x^8 + x^4 + x^3 + x + 1
    localparam byte_t GF_POLY = 8'h1b;

    localparam apb_addr_t ADDR_CTRL   = 8'h00;
    localparam apb_addr_t ADDR_STATUS = 8'h04;
    localparam apb_addr_t ADDR_KEY0   = 8'h10;
    localparam apb_addr_t ADDR_DIN0   = 8'h20;
    localparam apb_addr_t ADDR_DOUT0  = 8'h30;

    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        word_t     pwdata;
    } apb_req_t;

    typedef struct packed {
        logic       expand_en;
        logic       load;
        logic       round_en;
        logic       last;
        round_idx_t key_idx;
    } dec_ctl_t;

    typedef enum logic [1:0] {
        IDLE,
        EXPAND,
        LOAD,
        ROUND
    } dec_state_e;

endpackage

/* gf_sbox.sv */
`timescale 1ns/1ns

module gf_sbox
    import aes_dec_pkg::*;
#(
    parameter bit INVERSE = 1'b0
)
(
    input  byte_t in_byte,
    output byte_t out_byte
);

    function automatic byte_t gf_mul(byte_t a, byte_t b);
        byte_t acc;
        byte_t x;
        acc = '0;
        x = a;
        for (int i = 0; i < 8; i++)
        begin
            if (b[i])
                acc = acc ^ x;
            x = x[7] ? ((x << 1) ^ GF_POLY) : (x << 1);
        end
        return acc;
    endfunction

    // a^254, so zero maps to zero
    function automatic byte_t gf_inv(byte_t a);
        byte_t sq;
        byte_t acc;
        sq = a;
        acc = 8'h01;
        for (int i = 1; i < 8; i++)
        begin
            sq = gf_mul(sq, sq);
            acc = gf_mul(acc, sq);
        end
        return acc;
    endfunction

    function automatic byte_t rotl(byte_t a, int n);
        return (a << n) | (a >> (8 - n));
    endfunction

    always_comb
    begin
        if (INVERSE)
        begin
            // inverse affine first, then invert
            out_byte = gf_inv(rotl(in_byte, 1) ^ rotl(in_byte, 3) ^ rotl(in_byte, 6)
                              ^ 8'h05);
        end
        else
        begin
            out_byte = gf_inv(in_byte);
            out_byte = out_byte ^ rotl(out_byte, 1) ^ rotl(out_byte, 2)
                       ^ rotl(out_byte, 3) ^ rotl(out_byte, 4) ^ 8'h63;
        end
    end

endmodule

/* key_schedule.sv */
`timescale 1ns/1ns

module key_schedule
    import aes_dec_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  dec_ctl_t ctl,
    input  block_t   key,
    output block_t   round_key
);

    block_t     keys [0:NUM_ROUNDS];
    round_idx_t wr_idx;
    round_idx_t src_idx;
    block_t     prev_key;
    block_t     next_key;
    word_t      rot_word;
    word_t      sub_word;
    word_t      w0;
    word_t      w1;
    word_t      w2;
    word_t      w3;

    // first cycle derives key 1 straight from the cipher key
    assign src_idx  = (wr_idx == '0) ? '0 : wr_idx - 4'd1;
    assign prev_key = (wr_idx == '0) ? key : keys[src_idx];
    assign rot_word = {prev_key[23:0], prev_key[31:24]};

    for (genvar g = 0; g < 4; g++)
    begin : g_sub
        gf_sbox #(.INVERSE(1'b0)) u_sbox (
            .in_byte  (rot_word[8*g +: 8]),
            .out_byte (sub_word[8*g +: 8])
        );
    end

    always_comb
    begin
        w0 = prev_key[127:96] ^ sub_word ^ {RCON[src_idx], 24'h0};
        w1 = prev_key[95:64] ^ w0;
        w2 = prev_key[63:32] ^ w1;
        w3 = prev_key[31:0] ^ w2;
        next_key = {w0, w1, w2, w3};
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            wr_idx <= '0;
        else if (ctl.expand_en)
        begin
            if (wr_idx == NUM_ROUNDS)
                wr_idx <= '0;
            else if (wr_idx == '0)
                wr_idx <= 4'd2;
            else
                wr_idx <= wr_idx + 4'd1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i <= NUM_ROUNDS; i++)
                keys[i] <= '0;
        end
        else if (ctl.expand_en)
        begin
            if (wr_idx == '0)
            begin
                keys[0] <= key;
                keys[1] <= next_key;
            end
            else
                keys[wr_idx] <= next_key;
        end
    end

    assign round_key = keys[ctl.key_idx];

endmodule

/* inv_round.sv */
`timescale 1ns/1ns

module inv_round
    import aes_dec_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  dec_ctl_t ctl,
    input  block_t   din,
    input  block_t   round_key,
    output block_t   state
);

    block_t shifted;
    block_t subbed;
    block_t keyed;
    block_t mixed;

    function automatic byte_t xtime(byte_t a);
        return a[7] ? ((a << 1) ^ GF_POLY) : (a << 1);
    endfunction

    // coefficient below 16, built from doublings
    function automatic byte_t gmul(byte_t a, logic [3:0] coef);
        byte_t x2;
        byte_t x4;
        byte_t x8;
        x2 = xtime(a);
        x4 = xtime(x2);
        x8 = xtime(x4);
        return (coef[3] ? x8 : 8'h00) ^ (coef[2] ? x4 : 8'h00)
               ^ (coef[1] ? x2 : 8'h00) ^ (coef[0] ? a : 8'h00);
    endfunction

    function automatic word_t inv_mix_col(word_t col);
        byte_t a0;
        byte_t a1;
        byte_t a2;
        byte_t a3;
        word_t res;
        a0 = col[31:24];
        a1 = col[23:16];
        a2 = col[15:8];
        a3 = col[7:0];
        res[31:24] = gmul(a0, 4'he) ^ gmul(a1, 4'hb) ^ gmul(a2, 4'hd) ^ gmul(a3, 4'h9);
        res[23:16] = gmul(a0, 4'h9) ^ gmul(a1, 4'he) ^ gmul(a2, 4'hb) ^ gmul(a3, 4'hd);
        res[15:8]  = gmul(a0, 4'hd) ^ gmul(a1, 4'h9) ^ gmul(a2, 4'he) ^ gmul(a3, 4'hb);
        res[7:0]   = gmul(a0, 4'hb) ^ gmul(a1, 4'hd) ^ gmul(a2, 4'h9) ^ gmul(a3, 4'he);
        return res;
    endfunction

    // row r moves right by r columns, byte 0 sits in the top bits
    always_comb
    begin
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
            begin
                shifted[127 - 8*(4*c + r) -: 8] =
                    state[127 - 8*(4*((c - r + 4) % 4) + r) -: 8];
            end
        end
    end

    for (genvar n = 0; n < 16; n++)
    begin : g_sub
        gf_sbox #(.INVERSE(1'b1)) u_sbox (
            .in_byte  (shifted[8*n +: 8]),
            .out_byte (subbed[8*n +: 8])
        );
    end

    assign keyed = subbed ^ round_key;

    always_comb
    begin
        for (int c = 0; c < 4; c++)
            mixed[127 - 32*c -: 32] = inv_mix_col(keyed[127 - 32*c -: 32]);
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            state <= '0;
        else if (ctl.load)
            state <= din ^ round_key;
        else if (ctl.round_en)
            state <= ctl.last ? keyed : mixed;
    end

endmodule

/* dec_control.sv */
`timescale 1ns/1ns

module dec_control
    import aes_dec_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     start,
    output dec_ctl_t ctl,
    output logic     busy,
    output logic     done
);

    dec_state_e st;
    round_idx_t cnt;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            st   <= IDLE;
            cnt  <= '0;
            done <= 1'b0;
        end
        else
        begin
            case (st)
                IDLE:
                begin
                    if (start)
                    begin
                        st   <= EXPAND;
                        cnt  <= '0;
                        done <= 1'b0;
                    end
                end
                EXPAND:
                begin
                    if (cnt == NUM_ROUNDS - 4'd1)
                        st <= LOAD;
                    else
                        cnt <= cnt + 4'd1;
                end
                LOAD:
                begin
                    st  <= ROUND;
                    cnt <= NUM_ROUNDS - 4'd1;
                end
                ROUND:
                begin
                    // key 0 closes the last round
                    if (cnt == '0)
                    begin
                        st   <= IDLE;
                        done <= 1'b1;
                    end
                    else
                        cnt <= cnt - 4'd1;
                end
                default:
                    st <= IDLE;
            endcase
        end
    end

    always_comb
    begin
        ctl.expand_en = (st == EXPAND);
        ctl.load      = (st == LOAD);
        ctl.round_en  = (st == ROUND);
        ctl.last      = (st == ROUND) && (cnt == '0);
        ctl.key_idx   = (st == LOAD) ? NUM_ROUNDS : cnt;
    end

    assign busy = (st != IDLE);

endmodule

/* apb_regs.sv */
`timescale 1ns/1ns

module apb_regs
    import aes_dec_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  apb_req_t apb_req,
    output word_t    prdata,
    output logic     pready,
    output logic     pslverr,
    input  logic     busy,
    input  logic     done,
    input  block_t   result,
    output logic     start,
    output block_t   key,
    output block_t   din
);

    word_t       key_q [4];
    word_t       din_q [4];
    logic [1:0]  idx;
    logic        access;
    logic        aligned;
    logic        is_ctrl;
    logic        is_status;
    logic        is_key;
    logic        is_din;
    logic        is_dout;
    logic        wr_ok;

    assign access  = apb_req.psel && apb_req.penable;
    assign idx     = apb_req.paddr[3:2];
    assign aligned = (apb_req.paddr[1:0] == 2'b00);

    assign is_ctrl   = (apb_req.paddr == ADDR_CTRL);
    assign is_status = (apb_req.paddr == ADDR_STATUS);
    assign is_key    = aligned && (apb_req.paddr[7:4] == ADDR_KEY0[7:4]);
    assign is_din    = aligned && (apb_req.paddr[7:4] == ADDR_DIN0[7:4]);
    assign is_dout   = aligned && (apb_req.paddr[7:4] == ADDR_DOUT0[7:4]);

    // unmapped, read-only target, or operand change mid-run
    always_comb
    begin
        pslverr = 1'b0;
        if (access)
        begin
            if (!(is_ctrl || is_status || is_key || is_din || is_dout))
                pslverr = 1'b1;
            else if (apb_req.pwrite && (is_status || is_dout))
                pslverr = 1'b1;
            else if (apb_req.pwrite && busy
                     && (is_key || is_din || (is_ctrl && apb_req.pwdata[0])))
                pslverr = 1'b1;
        end
    end

    assign pready = 1'b1;
    assign wr_ok  = access && apb_req.pwrite && !pslverr;
    assign start  = wr_ok && is_ctrl && apb_req.pwdata[0];

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < 4; i++)
            begin
                key_q[i] <= '0;
                din_q[i] <= '0;
            end
        end
        else if (wr_ok)
        begin
            if (is_key)
                key_q[idx] <= apb_req.pwdata;
            if (is_din)
                din_q[idx] <= apb_req.pwdata;
        end
    end

    // word 0 is the most significant
    assign key = {key_q[0], key_q[1], key_q[2], key_q[3]};
    assign din = {din_q[0], din_q[1], din_q[2], din_q[3]};

    always_comb
    begin
        prdata = '0;
        if (is_status)
            prdata = {30'b0, done, busy};
        else if (is_key)
            prdata = key_q[idx];
        else if (is_din)
            prdata = din_q[idx];
        else if (is_dout && done)
            prdata = result[127 - 32*idx -: 32];
    end

endmodule

/* aes_dec_top.sv */
`timescale 1ns/1ns

module aes_dec_top
    import aes_dec_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  apb_req_t apb_req,
    output word_t    prdata,
    output logic     pready,
    output logic     pslverr
);

    logic     start;
    logic     busy;
    logic     done;
    block_t   key;
    block_t   din;
    block_t   round_key;
    block_t   state;
    dec_ctl_t ctl;

    apb_regs u_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .apb_req   (apb_req),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .busy      (busy),
        .done      (done),
        .result    (state),
        .start     (start),
        .key       (key),
        .din       (din)
    );

    dec_control u_ctrl (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .ctl   (ctl),
        .busy  (busy),
        .done  (done)
    );

    key_schedule u_keys (
        .clk       (clk),
        .rst_n     (rst_n),
        .ctl       (ctl),
        .key       (key),
        .round_key (round_key)
    );

    inv_round u_round (
        .clk       (clk),
        .rst_n     (rst_n),
        .ctl       (ctl),
        .din       (din),
        .round_key (round_key),
        .state     (state)
    );

endmodule

/* tb_apb_tasks.svh */
`ifndef TB_APB_TASKS_SVH
`define TB_APB_TASKS_SVH

// setup on one edge, access on the next, sampled mid-cycle
task automatic apb_access(input logic write, input apb_addr_t addr, input word_t wdata,
                          output word_t rdata, output logic err);
    @(posedge clk);
    apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
    @(posedge clk);
    apb_req.penable <= 1'b1;
    @(negedge clk);
    rdata = prdata;
    err = pslverr;
    check($sformatf("pready at %h", addr), 32'd1, {31'd0, pready});
endtask

task automatic apb_write(input apb_addr_t addr, input word_t data, output logic err);
    word_t unused_rdata;
    apb_access(1'b1, addr, data, unused_rdata, err);
endtask

task automatic apb_read(input apb_addr_t addr, output word_t data, output logic err);
    apb_access(1'b0, addr, 32'h0, data, err);
endtask

task automatic bus_idle();
    @(posedge clk);
    apb_req <= '0;
endtask

task automatic check(input string name, input word_t expected, input word_t actual);
    check_count++;
    if (actual !== expected)
    begin
        error_count++;
        $display("Error %s: expected %h, actual %h", name, expected, actual);
    end
endtask

function automatic word_t lcg_next(input word_t cur);
    return cur * 32'd1103515245 + 32'd12345;
endfunction

`endif

/* tb_aes_dec.sv */
`timescale 1ns/1ns

module tb_aes_dec
    import aes_dec_pkg::*;
();

    localparam int NUM_VEC      = 7;
    localparam int CLK_HALF     = 20;
    localparam int RESET_CYCLES = 10;
    localparam int MAX_CYCLES   = NUM_VEC * 60 + 200;

    typedef struct packed {
        block_t key;
        block_t ct;
        block_t pt;
    } vector_t;

    logic     clk = 1'b0;
    logic     rst_n;
    apb_req_t apb_req;
    word_t    prdata;
    logic     pready;
    logic     pslverr;

    vector_t vectors [NUM_VEC];
    string   vec_names [NUM_VEC];
    int      error_count = 0;
    int      check_count = 0;
    int      cycle_count = 0;
    word_t   lcg_state;

    `include "tb_apb_tasks.svh"

    aes_dec_top u_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .apb_req (apb_req),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #(CLK_HALF) clk = ~clk;

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES)
        begin
            $display("timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
            $display("Checks failed");
            $finish;
        end
    end

    function automatic apb_addr_t word_addr(input apb_addr_t base, input int i);
        return base + {i[5:0], 2'b00};
    endfunction

    // word 0 is the most significant
    function automatic word_t block_word(input block_t b, input int i);
        return b[127 - 32*i -: 32];
    endfunction

    task automatic load_vectors();
        vectors[0] = '{key: 128'h000102030405060708090a0b0c0d0e0f,
                       ct:  128'h69c4e0d86a7b0430d8cdb78070b4c55a,
                       pt:  128'h00112233445566778899aabbccddeeff};
        vec_names[0] = "fips197_c1";
        vectors[1] = '{key: 128'h2b7e151628aed2a6abf7158809cf4f3c,
                       ct:  128'h3925841d02dc09fbdc118597196a0b32,
                       pt:  128'h3243f6a8885a308d313198a2e0370734};
        vec_names[1] = "fips197_b";
        vectors[2] = '{key: 128'h2b7e151628aed2a6abf7158809cf4f3c,
                       ct:  128'h3ad77bb40d7a3660a89ecaf32466ef97,
                       pt:  128'h6bc1bee22e409f96e93d7e117393172a};
        vec_names[2] = "ecb_block1";
        vectors[3] = '{key: 128'h2b7e151628aed2a6abf7158809cf4f3c,
                       ct:  128'hf5d3d58503b9699de785895a96fdbaaf,
                       pt:  128'hae2d8a571e03ac9c9eb76fac45af8e51};
        vec_names[3] = "ecb_block2";
        vectors[4] = '{key: 128'h2b7e151628aed2a6abf7158809cf4f3c,
                       ct:  128'h43b1cd7f598ece23881b00e3ed030688,
                       pt:  128'h30c81c46a35ce411e5fbc1191a0a52ef};
        vec_names[4] = "ecb_block3";
        vectors[5] = '{key: 128'h2b7e151628aed2a6abf7158809cf4f3c,
                       ct:  128'h7b0c785e27e8ad3f8223207104725dd4,
                       pt:  128'hf69f2445df4f9b17ad2b417be66c3710};
        vec_names[5] = "ecb_block4";
        vectors[6] = '{key: 128'h0,
                       ct:  128'h66e94bd4ef8a2c3b884cfa59ca342b2e,
                       pt:  128'h0};
        vec_names[6] = "zero_key_kat";
    endtask

    task automatic write_block(input apb_addr_t base, input block_t value, input string name);
        logic err;
        for (int i = 0; i < 4; i++)
        begin
            apb_write(word_addr(base, i), block_word(value, i), err);
            check($sformatf("%s write %h pslverr", name, word_addr(base, i)), 32'd0, {31'd0, err});
        end
    endtask

    task automatic load_and_start(input int idx);
        word_t status;
        logic  err;
        write_block(ADDR_KEY0, vectors[idx].key, vec_names[idx]);
        write_block(ADDR_DIN0, vectors[idx].ct, vec_names[idx]);
        apb_write(ADDR_CTRL, 32'h1, err);
        check({vec_names[idx], " start pslverr"}, 32'd0, {31'd0, err});
        // done from the previous block must be cleared
        apb_read(ADDR_STATUS, status, err);
        check({vec_names[idx], " status after start"}, 32'h1, status);
    endtask

    task automatic wait_done(input string name);
        word_t status;
        logic  err;
        status = '0;
        while (status[1] == 1'b0)
            apb_read(ADDR_STATUS, status, err);
        check({name, " status when done"}, 32'h2, status);
    endtask

    task automatic check_result(input string name, input block_t pt);
        word_t data;
        logic  err;
        for (int i = 0; i < 4; i++)
        begin
            apb_read(word_addr(ADDR_DOUT0, i), data, err);
            check($sformatf("%s plaintext word %0d", name, i), block_word(pt, i), data);
        end
    endtask

    task automatic register_test();
        word_t  written [8];
        word_t  data;
        logic   err;
        apb_addr_t bad_addr [3];
        bad_addr = '{8'h08, 8'h40, 8'hfc};
        apb_read(ADDR_STATUS, data, err);
        check("status after reset", 32'h0, data);
        for (int i = 0; i < 8; i++)
        begin
            lcg_state = lcg_next(lcg_state);
            written[i] = lcg_state;
            apb_write(word_addr(ADDR_KEY0, i), written[i], err);
        end
        for (int i = 0; i < 8; i++)
        begin
            apb_read(word_addr(ADDR_KEY0, i), data, err);
            check($sformatf("readback %h", word_addr(ADDR_KEY0, i)), written[i], data);
        end
        for (int i = 0; i < 3; i++)
        begin
            apb_read(bad_addr[i], data, err);
            check($sformatf("unmapped %h data", bad_addr[i]), 32'h0, data);
            check($sformatf("unmapped %h pslverr", bad_addr[i]), 32'd1, {31'd0, err});
        end
    endtask

    task automatic busy_error_test(input int idx);
        word_t data;
        logic  err;
        load_and_start(idx);
        apb_write(ADDR_KEY0, ~block_word(vectors[idx].key, 0), err);
        check("key write while busy pslverr", 32'd1, {31'd0, err});
        apb_write(ADDR_DIN0, 32'h0, err);
        check("data write while busy pslverr", 32'd1, {31'd0, err});
        apb_write(ADDR_CTRL, 32'h1, err);
        check("second start pslverr", 32'd1, {31'd0, err});
        apb_read(ADDR_KEY0, data, err);
        check("key word 0 after rejected write", block_word(vectors[idx].key, 0), data);
        wait_done("busy_errors");
        check_result("busy_errors", vectors[idx].pt);
    endtask

    task automatic readonly_test(input int idx);
        word_t data;
        logic  err;
        apb_write(ADDR_STATUS, 32'h0, err);
        check("status write pslverr", 32'd1, {31'd0, err});
        apb_read(ADDR_STATUS, data, err);
        check("status after write", 32'h2, data);
        for (int i = 0; i < 4; i++)
        begin
            apb_write(word_addr(ADDR_DOUT0, i), 32'hffffffff, err);
            check($sformatf("result word %0d write pslverr", i), 32'd1, {31'd0, err});
        end
        check_result("after result writes", vectors[idx].pt);
    endtask

    initial
    begin
        rst_n = 1'b0;
        apb_req = '0;
        lcg_state = 32'd77;
        load_vectors();
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        register_test();
        // back to back, no reset in between
        for (int i = 0; i < NUM_VEC; i++)
        begin
            load_and_start(i);
            wait_done(vec_names[i]);
            check_result(vec_names[i], vectors[i].pt);
        end
        busy_error_test(1);
        readonly_test(1);
        bus_idle();

        $display("checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

/* project.f */
+incdir+.
aes_dec_pkg.sv
gf_sbox.sv
key_schedule.sv
inv_round.sv
dec_control.sv
apb_regs.sv
aes_dec_top.sv
tb_aes_dec.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_aes_dec
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SRCS := $(filter %.sv,$(shell cat $(FILELIST)))
HDRS := $(wildcard *.svh)
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM)
	$(SIM) | tee $(LOG)
	@grep -qx "All checks passed" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
